// File: vlog.f
src/demo_pkg.sv
src/periph_bus_if.sv
src/bus_decoder.sv
src/gpio.sv
src/timer.sv
src/pwm.sv
src/periph_subsys_top.sv
bench/periph_subsys_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the output for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module periph_subsys_tb -f vlog.f &&
./obj_dir/Vperiph_subsys_tb | tee /dev/stderr | grep -q "sim passed" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// File: bench/periph_subsys_tb.sv
// Testbench for the peripheral subsystem covering bus responses, GPIO, timer and PWM
`timescale 1ns/10ps
`default_nettype none

module periph_subsys_tb;

  localparam int GpiWidth      = 8;
  localparam int GpoWidth      = 16;
  localparam int PwmWidth      = 4;
  localparam int PwmCtrSize    = 8;
  localparam int ClkPeriod     = 10;
  localparam int NumTests      = 6;
  localparam int CyclesPerTest = 2000;

  localparam demo_pkg::addr_t GpoAddr     = demo_pkg::GpioBase + 32'(demo_pkg::GpioOutOff);
  localparam demo_pkg::addr_t GpiAddr     = demo_pkg::GpioBase + 32'(demo_pkg::GpioInOff);
  localparam demo_pkg::addr_t MtimeLoAddr = demo_pkg::TimerBase + 32'(demo_pkg::TimerLoOff);
  localparam demo_pkg::addr_t MtimeHiAddr = demo_pkg::TimerBase + 32'(demo_pkg::TimerHiOff);
  localparam demo_pkg::addr_t CmpLoAddr   = demo_pkg::TimerBase + 32'(demo_pkg::CmpLoOff);
  localparam demo_pkg::addr_t CmpHiAddr   = demo_pkg::TimerBase + 32'(demo_pkg::CmpHiOff);

  logic                  clk_sys_i;
  logic                  rst_sys_ni;
  logic                  bus_req_i;
  logic                  bus_we_i;
  demo_pkg::be_t         bus_be_i;
  demo_pkg::addr_t       bus_addr_i;
  demo_pkg::data_t       bus_wdata_i;
  logic                  bus_rvalid_o;
  demo_pkg::data_t       bus_rdata_o;
  logic                  bus_err_o;
  logic [GpiWidth-1:0]   gp_i;
  logic [GpoWidth-1:0]   gp_o;
  logic [PwmWidth-1:0]   pwm_o;
  logic                  timer_irq_o;

  logic [31:0]           lfsr_q;
  int unsigned           cyc_q = 0;
  string                 test_name;
  logic [31:0]           gpo_model; // Expected GPIO output register
  logic [PwmCtrSize-1:0] width_model  [PwmWidth];
  logic [PwmCtrSize-1:0] period_model [PwmWidth];

  periph_subsys_top #(
    .GpiWidth   (GpiWidth),
    .GpoWidth   (GpoWidth),
    .PwmWidth   (PwmWidth),
    .PwmCtrSize (PwmCtrSize)
  ) i_dut (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .bus_req_i    (bus_req_i),
    .bus_we_i     (bus_we_i),
    .bus_be_i     (bus_be_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_err_o    (bus_err_o),
    .gp_i         (gp_i),
    .gp_o         (gp_o),
    .pwm_o        (pwm_o),
    .timer_irq_o  (timer_irq_o)
  );

  always #(ClkPeriod / 2) clk_sys_i = ~clk_sys_i;

  always @(posedge clk_sys_i) begin
    cyc_q <= cyc_q + 1; // Cycle count for timer checks
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  // Each window spans 4 KiB upward from its base
  function automatic logic addr_mapped(input demo_pkg::addr_t addr);
    return ((addr - demo_pkg::GpioBase) < 32'h1000) ||
           ((addr - demo_pkg::TimerBase) < 32'h1000) ||
           ((addr - demo_pkg::PwmBase) < 32'h1000);
  endfunction

  task automatic report_mismatch(input string test, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test, exp, act);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic expect_equal(input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else report_mismatch(test_name, exp, act);
  endtask

  // Starts on a falling edge and returns on the next one with the response sampled
  task automatic issue_request(input logic we, input demo_pkg::be_t be,
                               input demo_pkg::addr_t addr, input demo_pkg::data_t wdata,
                               output demo_pkg::data_t rdata);
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_be_i    = be;
    bus_addr_i  = addr;
    bus_wdata_i = wdata;
    @(negedge clk_sys_i);
    bus_req_i = 1'b0;
    bus_we_i  = 1'b0;
    rdata     = bus_rdata_o;
  endtask

  task automatic write_reg(input demo_pkg::addr_t addr, input demo_pkg::data_t wdata);
    demo_pkg::data_t rdata;
    issue_request(1'b1, 4'hF, addr, wdata, rdata);
    expect_equal(64'd0, 64'(rdata)); // Writes answer with zero
  endtask

  task automatic read_reg(input demo_pkg::addr_t addr, output demo_pkg::data_t rdata);
    issue_request(1'b0, 4'hF, addr, '0, rdata);
  endtask

  task automatic reset_test();
    test_name = "reset";
    repeat (5) begin
      @(negedge clk_sys_i);
      expect_equal(64'd0, 64'({bus_rvalid_o, bus_err_o, gp_o, pwm_o, timer_irq_o}));
    end
    rst_sys_ni = 1'b1;
    @(negedge clk_sys_i);
    expect_equal(64'd0, 64'({bus_rvalid_o, bus_err_o, gp_o, pwm_o, timer_irq_o}));
  endtask

  task automatic response_test();
    demo_pkg::addr_t base;
    demo_pkg::addr_t addr;
    demo_pkg::data_t rdata;
    logic            we;
    test_name = "response";
    for (int i = 0; i < 300; i++) begin
      case (rand_bits(2))
        0: base = demo_pkg::GpioBase;
        1: base = demo_pkg::TimerBase;
        2: base = demo_pkg::PwmBase;
        default: base = rand_bits(20) << 12; // Mostly unmapped
      endcase
      addr = base | (rand_bits(10) << 2);
      we   = !addr_mapped(addr) && (rand_bits(1) != 0);
      if (rand_bits(2) == 0) begin
        @(negedge clk_sys_i);
      end else begin
        issue_request(we, 4'hF, addr, rand_bits(32), rdata);
      end
    end
  endtask

  task automatic gpio_test();
    demo_pkg::data_t wdata;
    demo_pkg::data_t rdata;
    demo_pkg::be_t   be;
    test_name = "gpio";
    for (int i = 0; i < 16; i++) begin
      wdata = rand_bits(32);
      be    = 4'(rand_bits(4));
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          gpo_model[b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
      issue_request(1'b1, be, GpoAddr, wdata, rdata);
      expect_equal(64'(gpo_model[GpoWidth-1:0]), 64'(gp_o));
      read_reg(GpoAddr, rdata);
      expect_equal(64'(gpo_model[GpoWidth-1:0]), 64'(rdata));
    end
    for (int i = 0; i < 8; i++) begin
      gp_i = GpiWidth'(rand_bits(GpiWidth));
      repeat (3) @(negedge clk_sys_i);
      read_reg(GpiAddr, rdata);
      expect_equal(64'(gp_i), 64'(rdata));
    end
  endtask

  task automatic timer_count_test();
    demo_pkg::data_t first;
    demo_pkg::data_t second;
    demo_pkg::data_t delta;
    demo_pkg::data_t wdata;
    int unsigned     k;
    test_name = "timer_count";
    for (int i = 0; i < 8; i++) begin
      k = 1 + rand_bits(6);
      read_reg(MtimeLoAddr, first);
      repeat (k - 1) @(negedge clk_sys_i);
      read_reg(MtimeLoAddr, second);
      delta = second - first;
      expect_equal(64'(k), 64'(delta));
    end
    wdata = rand_bits(31); // Top bit clear so no carry into the high half
    write_reg(MtimeLoAddr, wdata);
    @(negedge clk_sys_i);
    read_reg(MtimeLoAddr, first);
    delta = wdata + 32'd1;
    expect_equal(64'(delta), 64'(first));
  endtask

  task automatic timer_irq_test();
    demo_pkg::data_t hi;
    demo_pkg::data_t lo;
    logic [63:0]     cmp;
    int unsigned     t0;
    test_name = "timer_irq";
    read_reg(MtimeHiAddr, hi);
    read_reg(MtimeLoAddr, lo);
    t0  = cyc_q; // Edge count at which mtime equalled lo
    cmp = {hi, lo} + 64'd100;
    write_reg(CmpHiAddr, cmp[63:32]);
    write_reg(CmpLoAddr, cmp[31:0]);
    while (cyc_q - t0 < 100) begin
      expect_equal(64'd0, 64'(timer_irq_o));
      @(negedge clk_sys_i);
    end
    while (!timer_irq_o && (cyc_q - t0 < 102)) begin
      @(negedge clk_sys_i);
    end
    expect_equal(64'd1, 64'(timer_irq_o));
    repeat (20) begin
      @(negedge clk_sys_i);
      expect_equal(64'd1, 64'(timer_irq_o));
    end
    write_reg(CmpHiAddr, '1);
    write_reg(CmpLoAddr, '1);
    @(negedge clk_sys_i);
    expect_equal(64'd0, 64'(timer_irq_o));
  endtask

  task automatic pwm_test();
    demo_pkg::addr_t chan_base;
    demo_pkg::data_t rdata;
    int unsigned     high_cnt [PwmWidth];
    int unsigned     exp_cnt;
    test_name = "pwm";
    for (int c = 0; c < PwmWidth; c++) begin
      width_model[c]  = (c == 0) ? '0 : PwmCtrSize'(rand_bits(PwmCtrSize));
      period_model[c] = PwmCtrSize'(rand_bits(PwmCtrSize));
      chan_base       = demo_pkg::PwmBase + 32'(c * demo_pkg::PwmStride);
      write_reg(chan_base + 32'(demo_pkg::PwmWidthOff), 32'(width_model[c]));
      write_reg(chan_base + 32'(demo_pkg::PwmPeriodOff), 32'(period_model[c]));
      read_reg(chan_base + 32'(demo_pkg::PwmWidthOff), rdata);
      expect_equal(64'(width_model[c]), 64'(rdata));
      read_reg(chan_base + 32'(demo_pkg::PwmPeriodOff), rdata);
      expect_equal(64'(period_model[c]), 64'(rdata));
      high_cnt[c] = 0;
    end
    repeat (2) @(negedge clk_sys_i); // Let a shrunk period wrap
    for (int m = 0; m < 2 ** PwmCtrSize; m++) begin
      for (int c = 0; c < PwmWidth; c++) begin
        if (m <= int'(period_model[c]) && pwm_o[c]) begin
          high_cnt[c]++;
        end
      end
      @(negedge clk_sys_i);
    end
    for (int c = 0; c < PwmWidth; c++) begin
      exp_cnt = (int'(width_model[c]) < int'(period_model[c]) + 1) ?
                int'(width_model[c]) : int'(period_model[c]) + 1;
      expect_equal(64'(exp_cnt), 64'(high_cnt[c]));
    end
  endtask

  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    bus_req_i |=> bus_rvalid_o)
    else report_mismatch(test_name, 64'd1, 64'd0);

  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    !bus_req_i |=> !bus_rvalid_o)
    else report_mismatch(test_name, 64'd0, 64'd1);

  // Unmapped accesses answer with an error and no data
  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    bus_req_i && !addr_mapped(bus_addr_i) |=> bus_err_o)
    else report_mismatch(test_name, 64'd1, 64'd0);

  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    bus_req_i && !addr_mapped(bus_addr_i) |=> bus_rdata_o == '0)
    else report_mismatch(test_name, 64'd0, 64'($sampled(bus_rdata_o)));

  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    bus_req_i && addr_mapped(bus_addr_i) |=> !bus_err_o)
    else report_mismatch(test_name, 64'd0, 64'd1);

  initial begin
    #(NumTests * CyclesPerTest * ClkPeriod);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("sim failed");
    $fatal(1);
  end

  initial begin
    clk_sys_i   = 1'b0;
    rst_sys_ni  = 1'b0;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_be_i    = '0;
    bus_addr_i  = '0;
    bus_wdata_i = '0;
    gp_i        = '0;
    lfsr_q      = 32'ha0d2_4a59;
    gpo_model   = '0;
    test_name   = "reset";
    reset_test();
    response_test();
    gpio_test();
    timer_count_test();
    timer_irq_test();
    pwm_test();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/periph_subsys_top.sv
// Peripheral subsystem joining the host bus port, address decoder, GPIO, timer and PWM
`timescale 1ns/10ps
`default_nettype none

module periph_subsys_top #(
  parameter int GpiWidth   = 8,
  parameter int GpoWidth   = 16,
  parameter int PwmWidth   = 4,
  parameter int PwmCtrSize = 8
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,

  // Host port
  input  logic                bus_req_i,
  input  logic                bus_we_i,
  input  demo_pkg::be_t       bus_be_i,
  input  demo_pkg::addr_t     bus_addr_i,
  input  demo_pkg::data_t     bus_wdata_i,
  output logic                bus_rvalid_o,
  output demo_pkg::data_t     bus_rdata_o,
  output logic                bus_err_o,

  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o,
  output logic [PwmWidth-1:0] pwm_o,
  output logic                timer_irq_o
);

  periph_bus_if gpio_bus ();
  periph_bus_if timer_bus ();
  periph_bus_if pwm_bus ();

  bus_decoder u_bus_decoder (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .bus_req_i    (bus_req_i),
    .bus_we_i     (bus_we_i),
    .bus_be_i     (bus_be_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_err_o    (bus_err_o),
    .gpio_o       (gpio_bus.ctrl),
    .timer_o      (timer_bus.ctrl),
    .pwm_o        (pwm_bus.ctrl)
  );

  gpio #(
    .GpiWidth (GpiWidth),
    .GpoWidth (GpoWidth)
  ) u_gpio (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .gp_i       (gp_i),
    .gp_o       (gp_o),
    .bus_i      (gpio_bus.dev)
  );

  timer u_timer (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .timer_irq_o (timer_irq_o),
    .bus_i       (timer_bus.dev)
  );

  pwm #(
    .PwmWidth   (PwmWidth),
    .PwmCtrSize (PwmCtrSize)
  ) u_pwm (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .pwm_o      (pwm_o),
    .bus_i      (pwm_bus.dev)
  );

endmodule

`default_nettype wire

// File: src/pwm.sv
// Bank of PWM channels, each with width and period registers and a free-running counter
`timescale 1ns/10ps
`default_nettype none

module pwm #(
  parameter int PwmWidth   = 4,
  parameter int PwmCtrSize = 8
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,

  output logic [PwmWidth-1:0] pwm_o,

  periph_bus_if.dev           bus_i
);

  localparam int StrideBits = $clog2(demo_pkg::PwmStride);

  logic [PwmCtrSize-1:0]          width_q  [PwmWidth];
  logic [PwmCtrSize-1:0]          period_q [PwmWidth];
  logic [PwmCtrSize-1:0]          ctr_q    [PwmWidth];
  logic [demo_pkg::RegOffW-1:0]   chan_idx;
  logic [demo_pkg::RegOffW-1:0]   reg_off;
  logic [PwmWidth-1:0]            width_wr;
  logic [PwmWidth-1:0]            period_wr;
  demo_pkg::data_t                rd_word;

  assign chan_idx = bus_i.offset >> StrideBits;
  assign reg_off  = bus_i.offset & demo_pkg::RegOffW'(demo_pkg::PwmStride - 1);

  // Channels past the last one match nothing here
  always_comb begin
    rd_word = '0;
    for (int c = 0; c < PwmWidth; c++) begin
      width_wr[c]  = bus_i.req && bus_i.we && chan_idx == c &&
                     reg_off == demo_pkg::PwmWidthOff;
      period_wr[c] = bus_i.req && bus_i.we && chan_idx == c &&
                     reg_off == demo_pkg::PwmPeriodOff;
      if (chan_idx == c && reg_off == demo_pkg::PwmWidthOff) begin
        rd_word = demo_pkg::data_t'(width_q[c]);
      end else if (chan_idx == c && reg_off == demo_pkg::PwmPeriodOff) begin
        rd_word = demo_pkg::data_t'(period_q[c]);
      end
      pwm_o[c] = ctr_q[c] < width_q[c];
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      for (int c = 0; c < PwmWidth; c++) begin
        width_q[c]  <= '0;
        period_q[c] <= '0;
        ctr_q[c]    <= '0;
      end
    end else begin
      for (int c = 0; c < PwmWidth; c++) begin
        if (width_wr[c]) begin
          width_q[c] <= PwmCtrSize'(demo_pkg::be_merge(demo_pkg::data_t'(width_q[c]),
                                                       bus_i.wdata, bus_i.be));
        end
        if (period_wr[c]) begin
          period_q[c] <= PwmCtrSize'(demo_pkg::be_merge(demo_pkg::data_t'(period_q[c]),
                                                        bus_i.wdata, bus_i.be));
        end
        ctr_q[c] <= (ctr_q[c] >= period_q[c]) ? '0 : ctr_q[c] + 1'b1; // Wrap at period
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    bus_i.rdata <= (bus_i.req && !bus_i.we) ? rd_word : '0;
  end

  // A shrunk period may leave the counter above it for one cycle
  for (genvar c = 0; c < PwmWidth; c++) begin : g_ctr_chk
    assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
      !$past(period_wr[c]) |-> ctr_q[c] <= period_q[c]);
  end

endmodule

`default_nettype wire

// File: src/timer.sv
// Machine timer with 64-bit mtime, mtimecmp compare and a registered interrupt
`timescale 1ns/10ps
`default_nettype none

module timer (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,

  output logic      timer_irq_o,

  periph_bus_if.dev bus_i
);

  logic [63:0]     mtime_q;
  logic [63:0]     mtimecmp_q;
  logic            wr_en;
  demo_pkg::data_t rd_word;

  assign wr_en = bus_i.req && bus_i.we;

  // A write to either half replaces this cycle's increment
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q <= '0;
    end else if (wr_en && bus_i.offset == demo_pkg::TimerLoOff) begin
      mtime_q[31:0] <= demo_pkg::be_merge(mtime_q[31:0], bus_i.wdata, bus_i.be);
    end else if (wr_en && bus_i.offset == demo_pkg::TimerHiOff) begin
      mtime_q[63:32] <= demo_pkg::be_merge(mtime_q[63:32], bus_i.wdata, bus_i.be);
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtimecmp_q <= '1; // Disarmed
    end else if (wr_en && bus_i.offset == demo_pkg::CmpLoOff) begin
      mtimecmp_q[31:0] <= demo_pkg::be_merge(mtimecmp_q[31:0], bus_i.wdata, bus_i.be);
    end else if (wr_en && bus_i.offset == demo_pkg::CmpHiOff) begin
      mtimecmp_q[63:32] <= demo_pkg::be_merge(mtimecmp_q[63:32], bus_i.wdata, bus_i.be);
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      timer_irq_o <= 1'b0;
    end else begin
      timer_irq_o <= (mtime_q >= mtimecmp_q);
    end
  end

  always_comb begin
    case (bus_i.offset)
      demo_pkg::TimerLoOff: rd_word = mtime_q[31:0];
      demo_pkg::TimerHiOff: rd_word = mtime_q[63:32];
      demo_pkg::CmpLoOff:   rd_word = mtimecmp_q[31:0];
      demo_pkg::CmpHiOff:   rd_word = mtimecmp_q[63:32];
      default:              rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    bus_i.rdata <= (bus_i.req && !bus_i.we) ? rd_word : '0;
  end

  // Compare held at all ones keeps the interrupt quiet on the next cycle
  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    (&mtimecmp_q) |=> !timer_irq_o);

endmodule

`default_nettype wire

// File: src/gpio.sv
// GPIO block with a byte-writable output register and synchronized inputs
`timescale 1ns/10ps
`default_nettype none

module gpio #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,

  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o,

  periph_bus_if.dev           bus_i
);

  logic [GpiWidth-1:0] gpi_meta_q;
  logic [GpiWidth-1:0] gpi_sync_q;
  demo_pkg::data_t     rd_word;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o <= '0;
    end else if (bus_i.req && bus_i.we && bus_i.offset == demo_pkg::GpioOutOff) begin
      gp_o <= GpoWidth'(demo_pkg::be_merge(demo_pkg::data_t'(gp_o), bus_i.wdata, bus_i.be));
    end
  end

  always_comb begin
    case (bus_i.offset)
      demo_pkg::GpioOutOff: rd_word = demo_pkg::data_t'(gp_o);
      demo_pkg::GpioInOff:  rd_word = demo_pkg::data_t'(gpi_sync_q);
      default:              rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    bus_i.rdata <= (bus_i.req && !bus_i.we) ? rd_word : '0; // Writes return zero
  end

  // Idle bus cycles carry no read data
  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    !bus_i.rvalid |-> bus_i.rdata == '0);

endmodule

`default_nettype wire

// File: src/bus_decoder.sv
// Address decoder steering host requests to GPIO, timer or PWM and muxing their responses
`timescale 1ns/10ps
`default_nettype none

module bus_decoder (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,

  input  logic                  bus_req_i,
  input  logic                  bus_we_i,
  input  demo_pkg::be_t         bus_be_i,
  input  demo_pkg::addr_t       bus_addr_i,
  input  demo_pkg::data_t       bus_wdata_i,
  output logic                  bus_rvalid_o,
  output demo_pkg::data_t       bus_rdata_o,
  output logic                  bus_err_o,

  periph_bus_if.ctrl            gpio_o,
  periph_bus_if.ctrl            timer_o,
  periph_bus_if.ctrl            pwm_o
);

  demo_pkg::bus_device_e dev_sel;
  demo_pkg::bus_device_e dev_q; // Device of the request now responding
  logic                  err_q;

  always_comb begin
    if ((bus_addr_i & demo_pkg::DevMask) == demo_pkg::GpioBase) begin
      dev_sel = demo_pkg::DevGpio;
    end else if ((bus_addr_i & demo_pkg::DevMask) == demo_pkg::TimerBase) begin
      dev_sel = demo_pkg::DevTimer;
    end else if ((bus_addr_i & demo_pkg::DevMask) == demo_pkg::PwmBase) begin
      dev_sel = demo_pkg::DevPwm;
    end else begin
      dev_sel = demo_pkg::DevNone;
    end
  end

  // Request fields go to every peripheral and only req is steered
  assign gpio_o.req    = bus_req_i && (dev_sel == demo_pkg::DevGpio);
  assign gpio_o.we     = bus_we_i;
  assign gpio_o.be     = bus_be_i;
  assign gpio_o.offset = bus_addr_i[demo_pkg::RegOffW-1:0];
  assign gpio_o.wdata  = bus_wdata_i;

  assign timer_o.req    = bus_req_i && (dev_sel == demo_pkg::DevTimer);
  assign timer_o.we     = bus_we_i;
  assign timer_o.be     = bus_be_i;
  assign timer_o.offset = bus_addr_i[demo_pkg::RegOffW-1:0];
  assign timer_o.wdata  = bus_wdata_i;

  assign pwm_o.req    = bus_req_i && (dev_sel == demo_pkg::DevPwm);
  assign pwm_o.we     = bus_we_i;
  assign pwm_o.be     = bus_be_i;
  assign pwm_o.offset = bus_addr_i[demo_pkg::RegOffW-1:0];
  assign pwm_o.wdata  = bus_wdata_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      dev_q <= demo_pkg::DevNone;
      err_q <= 1'b0;
    end else begin
      dev_q <= bus_req_i ? dev_sel : demo_pkg::DevNone;
      err_q <= bus_req_i && (dev_sel == demo_pkg::DevNone); // Unmapped access
    end
  end

  always_comb begin
    bus_rvalid_o = err_q;
    bus_rdata_o  = '0;
    case (dev_q)
      demo_pkg::DevGpio: begin
        bus_rvalid_o = gpio_o.rvalid;
        bus_rdata_o  = gpio_o.rdata;
      end
      demo_pkg::DevTimer: begin
        bus_rvalid_o = timer_o.rvalid;
        bus_rdata_o  = timer_o.rdata;
      end
      demo_pkg::DevPwm: begin
        bus_rvalid_o = pwm_o.rvalid;
        bus_rdata_o  = pwm_o.rdata;
      end
      default: ;
    endcase
  end

  assign bus_err_o = err_q;

  // At most one source answers in any cycle
  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $onehot0({gpio_o.rvalid, timer_o.rvalid, pwm_o.rvalid, err_q}));

endmodule

`default_nettype wire

// File: src/periph_bus_if.sv
// Register bus from the address decoder to a single peripheral
`timescale 1ns/10ps
`default_nettype none

interface periph_bus_if;

  logic                         req;
  logic                         we;
  demo_pkg::be_t                be;
  logic [demo_pkg::RegOffW-1:0] offset; // Byte offset inside the window
  demo_pkg::data_t              wdata;
  logic                         rvalid; // req delayed by one cycle
  demo_pkg::data_t              rdata;

  modport ctrl (
    output req, we, be, offset, wdata,
    input  rvalid, rdata
  );

  modport dev (
    input  req, we, be, offset, wdata,
    output rvalid, rdata
  );

endinterface

`default_nettype wire

// File: src/demo_pkg.sv
// Shared widths, bus types, device select and address map of the peripheral subsystem
`default_nettype none

package demo_pkg;

  localparam int DataWidth = 32;
  localparam int AddrWidth = 32;

  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth/8-1:0] be_t;

  typedef enum logic [1:0] {
    DevGpio,
    DevTimer,
    DevPwm,
    DevNone
  } bus_device_e;

  // Each peripheral owns one 4 KiB window
  localparam int    RegOffW   = 12;
  localparam addr_t GpioBase  = 32'h8000_0000;
  localparam addr_t TimerBase = 32'h8000_2000;
  localparam addr_t PwmBase   = 32'h8000_3000;
  localparam addr_t DevMask   = ~((addr_t'(1) << RegOffW) - addr_t'(1));

  localparam logic [RegOffW-1:0] GpioOutOff = 12'h0;
  localparam logic [RegOffW-1:0] GpioInOff  = 12'h4;

  localparam logic [RegOffW-1:0] TimerLoOff = 12'h0;
  localparam logic [RegOffW-1:0] TimerHiOff = 12'h4;
  localparam logic [RegOffW-1:0] CmpLoOff   = 12'h8;
  localparam logic [RegOffW-1:0] CmpHiOff   = 12'hC;

  localparam logic [RegOffW-1:0] PwmWidthOff  = 12'h0;
  localparam logic [RegOffW-1:0] PwmPeriodOff = 12'h4;
  localparam int                 PwmStride    = 8; // Bytes per channel

  // Byte lane merge for partial writes
  function automatic data_t be_merge(data_t old_word, data_t wdata, be_t be);
    data_t merged;
    for (int i = 0; i < $bits(be_t); i++) begin
      merged[i*8 +: 8] = be[i] ? wdata[i*8 +: 8] : old_word[i*8 +: 8];
    end
    return merged;
  endfunction

endpackage

`default_nettype wire
